/* files.f */
source/apu_pkg.sv
source/voice_ctrl_if.sv
source/apu_regs.sv
source/square_voice.sv
source/channel_mixer.sv
source/sample_output.sv
source/apu_top.sv
verification/apu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build apu_tb with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module apu_tb -Mdir obj_dir -o apu_sim
	./obj_dir/apu_sim 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* verification/apu_golden.txt */
# test <name> | wr <addr hex> <data hex> | idle <cycles> | saw <samples>
# smp <sel 0..3> <samples> <left high hex> <right high hex> <min high> <max high>
test reset_saw
idle 30
saw 70
test duty_volume
wr 11 80
wr 12 a0
wr 13 f9
wr 14 87
smp 0 200 500000 500000 70 130
test length_expiry
wr 16 bc
wr 17 f0
wr 18 00
wr 19 c0
smp 1 1 780000 780000 1 1
idle 400
smp 1 20 0 0 0 0
test pan_master
wr 25 10
wr 24 30
smp 2 40 0a0000 000000 5 35
test power_gate
wr 26 00
wr 14 87
wr 25 11
wr 26 80
smp 2 20 0 0 0 0
smp 0 20 0 0 0 0
saw 4

/* verification/apu_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module apu_tb;

    localparam int STROBE_GAP = 50;
    localparam int VALID_WAIT = 4; // cycles allowed for out_valid

    logic                         clk_100;
    logic                         rst;
    logic                         reg_wr;
    logic [7:0]                   reg_addr;
    logic [7:0]                   reg_data;
    logic                         sample_strobe;
    apu_pkg::source_sel_t         source_sel;
    logic                         out_valid;
    logic [apu_pkg::SAMPLE_W-1:0] out_left;
    logic [apu_pkg::SAMPLE_W-1:0] out_right;

    integer     seed;
    string      test_name;
    logic [5:0] saw_exp; // next ramp value expected

    apu_top UUT (
        .clk_100       (clk_100),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .sample_strobe (sample_strobe),
        .source_sel    (source_sel),
        .out_valid     (out_valid),
        .out_left      (out_left),
        .out_right     (out_right)
    );

    initial begin
        clk_100 = 1'b0;
        forever #10 clk_100 = ~clk_100;
    end

    task automatic step; // edge, then drive delay
        @(posedge clk_100);
        #2;
    endtask

    task automatic stop_run;
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_sample(input string what,
                                  input logic [apu_pkg::SAMPLE_W-1:0] expected,
                                  input logic [apu_pkg::SAMPLE_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        reg_addr = addr;
        reg_data = data;
        reg_wr   = 1'b1;
        step();
        reg_wr = 1'b0;
        step(); // write has landed by now
    endtask

    // no strobe here, so out_valid must stay low
    task automatic idle_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            step();
            if (out_valid) begin
                $display("out_valid went high without a sample strobe in %s", test_name);
                stop_run();
            end
        end
    endtask

    task automatic take_sample(input apu_pkg::source_sel_t sel);
        int gap;
        int waited;
        gap = STROBE_GAP + ({$random(seed)} % 8);
        idle_cycles(gap);
        source_sel    = sel;
        sample_strobe = 1'b1;
        step();
        sample_strobe = 1'b0;
        waited        = 0;
        while (!out_valid) begin
            if (waited == VALID_WAIT) begin
                $display("timeout waiting for out_valid after a strobe in %s", test_name);
                stop_run();
            end
            waited++;
            step();
        end
    endtask

    // every sample is silence or the high value on both sides
    task automatic check_samples(input apu_pkg::source_sel_t sel, input int n,
                                 input logic [apu_pkg::SAMPLE_W-1:0] left_hi,
                                 input logic [apu_pkg::SAMPLE_W-1:0] right_hi,
                                 input int min_hi, input int max_hi);
        int   i;
        int   highs;
        logic hi;
        highs = 0;
        for (i = 0; i < n; i++) begin
            take_sample(sel);
            hi = (out_left != '0);
            if (hi) highs++;
            compare_sample("left", hi ? left_hi : '0, out_left);
            compare_sample("right", hi ? right_hi : '0, out_right);
        end
        if (highs < min_hi || highs > max_hi) begin
            $display("Error: %s high samples expected %0d..%0d actual %0d",
                     test_name, min_hi, max_hi, highs);
            stop_run();
        end
    endtask

    task automatic check_saw(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            take_sample(apu_pkg::SEL_SAW);
            compare_sample("saw left", {saw_exp, 18'd0}, out_left);
            compare_sample("saw right", {saw_exp, 18'd0}, out_right);
            saw_exp = saw_exp + 6'd1; // 6-bit ramp wraps at 64
        end
    endtask

    initial begin
        int                           fd;
        int                           nread;
        int                           cnt;
        int                           sel_raw;
        int                           min_hi;
        int                           max_hi;
        string                        line;
        string                        cmd;
        logic [7:0]                   addr_v;
        logic [7:0]                   data_v;
        logic [apu_pkg::SAMPLE_W-1:0] left_hi;
        logic [apu_pkg::SAMPLE_W-1:0] right_hi;

        seed          = 32'hc2f9;
        rst           = 1'b1;
        reg_wr        = 1'b0;
        reg_addr      = 8'h00;
        reg_data      = 8'h00;
        sample_strobe = 1'b0;
        source_sel    = apu_pkg::SEL_VOICE1;
        test_name     = "reset";
        saw_exp       = 6'd0;
        repeat (10) @(posedge clk_100);
        #2;
        rst = 1'b0;
        compare_sample("left after reset", '0, out_left);
        compare_sample("right after reset", '0, out_right);

        fd = $fopen("verification/apu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/apu_golden.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            line  = "";
            nread = $fgets(line, fd);
            if ($sscanf(line, "%s", cmd) < 1 || cmd == "#") continue;
            if (cmd == "test") begin
                nread = $sscanf(line, "%s %s", cmd, test_name);
                $display("running %s", test_name);
            end else if (cmd == "wr") begin
                nread = $sscanf(line, "%s %h %h", cmd, addr_v, data_v);
                write_reg(addr_v, data_v);
            end else if (cmd == "idle") begin
                nread = $sscanf(line, "%s %d", cmd, cnt);
                idle_cycles(cnt);
            end else if (cmd == "saw") begin
                nread = $sscanf(line, "%s %d", cmd, cnt);
                check_saw(cnt);
            end else if (cmd == "smp") begin
                nread = $sscanf(line, "%s %d %d %h %h %d %d", cmd, sel_raw, cnt,
                                left_hi, right_hi, min_hi, max_hi);
                check_samples(apu_pkg::source_sel_t'(sel_raw[1:0]), cnt,
                              left_hi, right_hi, min_hi, max_hi);
            end else begin
                $display("unknown command %s in the golden file", cmd);
                stop_run();
            end
        end
        $fclose(fd);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/apu_top.sv */
`default_nettype none
`timescale 1ns/1ns

module apu_top (
    input  logic                         clk_100,
    input  logic                         rst,
    input  logic                         reg_wr,
    input  logic [7:0]                   reg_addr,
    input  logic [7:0]                   reg_data,
    input  logic                         sample_strobe,
    input  apu_pkg::source_sel_t         source_sel,
    output logic                         out_valid,
    output logic [apu_pkg::SAMPLE_W-1:0] out_left,
    output logic [apu_pkg::SAMPLE_W-1:0] out_right
);

    logic [apu_pkg::LEVEL_W-1:0]  level1;
    logic [apu_pkg::LEVEL_W-1:0]  level2;
    logic [7:0]                   nr50;
    logic [7:0]                   nr51;
    logic [apu_pkg::SAMPLE_W-1:0] mix_left;
    logic [apu_pkg::SAMPLE_W-1:0] mix_right;

    voice_ctrl_if v1_ctrl ();
    voice_ctrl_if v2_ctrl ();

    apu_regs regs (
        .clk_100  (clk_100),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .nr50     (nr50),
        .nr51     (nr51),
        .v1       (v1_ctrl),
        .v2       (v2_ctrl)
    );

    // each voice carries its own length divider
    square_voice voice1 (.clk_100(clk_100), .rst(rst), .ctrl(v1_ctrl), .level(level1));
    square_voice voice2 (.clk_100(clk_100), .rst(rst), .ctrl(v2_ctrl), .level(level2));

    channel_mixer mixer (
        .level1    (level1),
        .level2    (level2),
        .nr50      (nr50),
        .nr51      (nr51),
        .mix_left  (mix_left),
        .mix_right (mix_right)
    );

    sample_output out_stage (
        .clk_100       (clk_100),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .source_sel    (source_sel),
        .level1        (level1),
        .level2        (level2),
        .mix_left      (mix_left),
        .mix_right     (mix_right),
        .out_valid     (out_valid),
        .out_left      (out_left),
        .out_right     (out_right)
    );

endmodule

`default_nettype wire

/* source/sample_output.sv */
`default_nettype none
`timescale 1ns/1ns

module sample_output (
    input  logic                         clk_100,
    input  logic                         rst,
    input  logic                         sample_strobe,
    input  apu_pkg::source_sel_t         source_sel,
    input  logic [apu_pkg::LEVEL_W-1:0]  level1,
    input  logic [apu_pkg::LEVEL_W-1:0]  level2,
    input  logic [apu_pkg::SAMPLE_W-1:0] mix_left,
    input  logic [apu_pkg::SAMPLE_W-1:0] mix_right,
    output logic                         out_valid,
    output logic [apu_pkg::SAMPLE_W-1:0] out_left,
    output logic [apu_pkg::SAMPLE_W-1:0] out_right
);

    logic [5:0]                   saw;     // test ramp
    logic [apu_pkg::SAMPLE_W-1:0] voice1_s;
    logic [apu_pkg::SAMPLE_W-1:0] voice2_s;

    assign voice1_s = {{(apu_pkg::SAMPLE_W - apu_pkg::LEVEL_W){1'b0}}, level1}
                      << apu_pkg::VOICE_SHIFT;
    assign voice2_s = {{(apu_pkg::SAMPLE_W - apu_pkg::LEVEL_W){1'b0}}, level2}
                      << apu_pkg::VOICE_SHIFT;

    always_ff @(posedge clk_100) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_left  <= '0;
            out_right <= '0;
            saw       <= '0;
        end else begin
            out_valid <= sample_strobe; // outputs hold between strobes
            if (sample_strobe) begin
                case (source_sel)
                    apu_pkg::SEL_VOICE1: begin
                        out_left  <= voice1_s;
                        out_right <= voice1_s;
                    end
                    apu_pkg::SEL_VOICE2: begin
                        out_left  <= voice2_s;
                        out_right <= voice2_s;
                    end
                    apu_pkg::SEL_MIX: begin
                        out_left  <= mix_left;
                        out_right <= mix_right;
                    end
                    apu_pkg::SEL_SAW: begin
                        out_left  <= {saw, 18'd0};
                        out_right <= {saw, 18'd0};
                        saw       <= saw + 6'd1; // wraps at 64
                    end
                endcase
            end
        end
    end

    // last sample stays put until the next strobe
    hold_between_strobes: assert property (@(posedge clk_100) disable iff (rst)
        !out_valid |-> $stable(out_left) && $stable(out_right))
        else $error("output changed without a strobe");

endmodule

`default_nettype wire

/* source/channel_mixer.sv */
`default_nettype none
`timescale 1ns/1ns

module channel_mixer (
    input  logic [apu_pkg::LEVEL_W-1:0]  level1,
    input  logic [apu_pkg::LEVEL_W-1:0]  level2,
    input  logic [7:0]                   nr50,
    input  logic [7:0]                   nr51,
    output logic [apu_pkg::SAMPLE_W-1:0] mix_left,
    output logic [apu_pkg::SAMPLE_W-1:0] mix_right
);

    // sum of routed voices times (master volume + 1)
    function automatic logic [apu_pkg::SAMPLE_W-1:0] side_mix(
        input logic [apu_pkg::LEVEL_W-1:0] a,
        input logic [apu_pkg::LEVEL_W-1:0] b,
        input logic                        en_a,
        input logic                        en_b,
        input logic [2:0]                  vol
    );
        logic [apu_pkg::LEVEL_W:0]    sum;
        logic [apu_pkg::SAMPLE_W-1:0] wide_sum;
        logic [apu_pkg::SAMPLE_W-1:0] wide_vol;
        sum      = (en_a ? {1'b0, a} : '0) + (en_b ? {1'b0, b} : '0);
        wide_sum = {{(apu_pkg::SAMPLE_W - apu_pkg::LEVEL_W - 1){1'b0}}, sum};
        wide_vol = {{(apu_pkg::SAMPLE_W - 4){1'b0}}, {1'b0, vol} + 4'd1}; // 1..8
        return (wide_sum * wide_vol) << apu_pkg::MIX_SHIFT;
    endfunction

    always_comb begin
        mix_left  = side_mix(level1, level2, nr51[4], nr51[5], nr50[6:4]);
        mix_right = side_mix(level1, level2, nr51[0], nr51[1], nr50[2:0]);
    end

endmodule

`default_nettype wire

/* source/square_voice.sv */
`default_nettype none
`timescale 1ns/1ns

module square_voice (
    input  logic                        clk_100,
    input  logic                        rst,
    voice_ctrl_if.voice                 ctrl,
    output logic [apu_pkg::LEVEL_W-1:0] level
);

    apu_pkg::voice_state_t state;
    logic [13:0] period;    // (2048 - freq) * TIMER_DIV
    logic [13:0] timer;
    logic [2:0]  duty_pos;
    logic [5:0]  len_cnt;
    logic [15:0] frame_cnt;
    logic        frame_tick;

    function automatic logic duty_bit(input logic [1:0] duty, input logic [2:0] pos);
        logic [7:0] pattern;
        case (duty)
            2'd0:    pattern = 8'b0000_0001; // 12.5 %
            2'd1:    pattern = 8'b1000_0001; // 25 %
            2'd2:    pattern = 8'b1000_0111; // 50 %
            default: pattern = 8'b0111_1110; // 75 %
        endcase
        return pattern[pos];
    endfunction

    assign period     = (14'd2048 - {3'b000, ctrl.freq}) * 14'(apu_pkg::TIMER_DIV);
    assign frame_tick = (frame_cnt == 16'(apu_pkg::FRAME_DIV - 1));

    always_ff @(posedge clk_100) begin
        if (rst || ctrl.power_off) begin
            state     <= apu_pkg::VOICE_IDLE;
            timer     <= '0;
            duty_pos  <= '0;
            len_cnt   <= '0;
            frame_cnt <= '0;
        end else if (ctrl.trigger) begin
            // restart from the top of the pattern
            state     <= apu_pkg::VOICE_PLAYING;
            timer     <= period - 14'd1;
            duty_pos  <= '0;
            len_cnt   <= ctrl.length;
            frame_cnt <= '0;
        end else if (state == apu_pkg::VOICE_PLAYING) begin
            if (timer == '0) begin
                timer    <= period - 14'd1;
                duty_pos <= duty_pos + 3'd1;
            end else begin
                timer <= timer - 14'd1;
            end

            frame_cnt <= frame_tick ? '0 : frame_cnt + 16'd1;

            // length counts up, voice stops when it passes 63
            if (frame_tick && ctrl.length_en) begin
                if (len_cnt == 6'd63) begin
                    state <= apu_pkg::VOICE_IDLE;
                end else begin
                    len_cnt <= len_cnt + 6'd1;
                end
            end
        end
    end

    assign level = (state == apu_pkg::VOICE_PLAYING && duty_bit(ctrl.duty, duty_pos))
                   ? ctrl.volume : '0;

    // powered-down voice goes silent on the next cycle
    silent_when_off: assert property (@(posedge clk_100) disable iff (rst)
        ctrl.power_off |=> level == '0) else $error("voice still sounding after power off");

endmodule

`default_nettype wire

/* source/apu_regs.sv */
`default_nettype none
`timescale 1ns/1ns

module apu_regs (
    input  logic       clk_100,
    input  logic       rst,
    input  logic       reg_wr,
    input  logic [7:0] reg_addr,
    input  logic [7:0] reg_data,
    output logic [7:0] nr50,
    output logic [7:0] nr51,
    voice_ctrl_if.regs v1,
    voice_ctrl_if.regs v2
);

    logic power_on; // NR52 bit 7

    // NR52 stays writable while everything else is locked
    always_ff @(posedge clk_100) begin
        if (rst) begin
            power_on <= 1'b1;
        end else if (reg_wr && reg_addr == apu_pkg::NR52) begin
            power_on <= reg_data[7];
        end
    end

    always_ff @(posedge clk_100) begin
        if (rst || !power_on) begin
            nr50         <= '0;
            nr51         <= '0;
            v1.duty      <= '0;
            v1.length    <= '0;
            v1.length_en <= 1'b0;
            v1.volume    <= '0;
            v1.freq      <= '0;
            v1.trigger   <= 1'b0;
            v2.duty      <= '0;
            v2.length    <= '0;
            v2.length_en <= 1'b0;
            v2.volume    <= '0;
            v2.freq      <= '0;
            v2.trigger   <= 1'b0;
        end else begin
            // trigger bit is write-only, never stored
            v1.trigger <= reg_wr && reg_addr == apu_pkg::NR14 && reg_data[7];
            v2.trigger <= reg_wr && reg_addr == apu_pkg::NR24 && reg_data[7];
            if (reg_wr) begin
                case (reg_addr)
                    apu_pkg::NR11: begin
                        v1.duty   <= reg_data[7:6];
                        v1.length <= reg_data[5:0];
                    end
                    apu_pkg::NR12: v1.volume    <= reg_data[7:4]; // envelope bits dropped
                    apu_pkg::NR13: v1.freq[7:0] <= reg_data;
                    apu_pkg::NR14: begin
                        v1.length_en  <= reg_data[6];
                        v1.freq[10:8] <= reg_data[2:0];
                    end
                    apu_pkg::NR21: begin
                        v2.duty   <= reg_data[7:6];
                        v2.length <= reg_data[5:0];
                    end
                    apu_pkg::NR22: v2.volume    <= reg_data[7:4];
                    apu_pkg::NR23: v2.freq[7:0] <= reg_data;
                    apu_pkg::NR24: begin
                        v2.length_en  <= reg_data[6];
                        v2.freq[10:8] <= reg_data[2:0];
                    end
                    apu_pkg::NR50: nr50 <= reg_data;
                    apu_pkg::NR51: nr51 <= reg_data;
                    default: ;
                endcase
            end
        end
    end

    assign v1.power_off = !power_on;
    assign v2.power_off = !power_on;

    // a single reg_wr pulse must give exactly one restart
    v1_trigger_pulse: assert property (@(posedge clk_100) disable iff (rst)
        v1.trigger |=> !v1.trigger) else $error("voice 1 trigger held two cycles");
    v2_trigger_pulse: assert property (@(posedge clk_100) disable iff (rst)
        v2.trigger |=> !v2.trigger) else $error("voice 2 trigger held two cycles");

endmodule

`default_nettype wire

/* source/voice_ctrl_if.sv */
`default_nettype none
`timescale 1ns/1ns

// settings of one square voice, register file to voice
interface voice_ctrl_if;

    logic [1:0]                  duty;
    logic [5:0]                  length;    // start value of the up-counter
    logic                        length_en;
    logic [apu_pkg::LEVEL_W-1:0] volume;
    logic [10:0]                 freq;
    logic                        trigger;   // one-cycle restart pulse
    logic                        power_off;

    modport regs (
        output duty, length, length_en, volume, freq, trigger, power_off
    );

    modport voice (
        input duty, length, length_en, volume, freq, trigger, power_off
    );

endinterface

`default_nettype wire

/* source/apu_pkg.sv */
`default_nettype none

package apu_pkg;

    // low byte of the NRxx register map
    typedef enum logic [7:0] {
        NR11 = 8'h11, // duty and length
        NR12 = 8'h12, // volume
        NR13 = 8'h13, // freq low
        NR14 = 8'h14, // trigger, length enable, freq high
        NR21 = 8'h16,
        NR22 = 8'h17,
        NR23 = 8'h18,
        NR24 = 8'h19,
        NR50 = 8'h24, // master volume
        NR51 = 8'h25, // panning
        NR52 = 8'h26  // power
    } reg_addr_t;

    typedef enum logic [1:0] {
        SEL_VOICE1,
        SEL_VOICE2,
        SEL_MIX,
        SEL_SAW
    } source_sel_t;

    typedef enum logic {
        VOICE_IDLE,
        VOICE_PLAYING
    } voice_state_t;

    localparam int TIMER_DIV   = 4;  // clk_100 cycles per timer step
    localparam int FRAME_DIV   = 64; // length tick, shortened for sim
    localparam int SAMPLE_W    = 24;
    localparam int LEVEL_W     = 4;
    localparam int VOICE_SHIFT = 19;
    localparam int MIX_SHIFT   = 14;

endpackage

`default_nettype wire
